// File: logic/tele_pkg.sv
package tele_pkg;

  // Widths of the watched controller state
  localparam int FSM_BITS = 5;
  localparam int DDL_BITS = 3;
  localparam int CMD_BITS = 3;

  // One record prints as six hex digits
  localparam int REC_BITS = 24;
  localparam int DIGITS = REC_BITS / 4;

  // Sent after the last digit of each record
  localparam logic [7:0] LINE_END = 8'h0A;

  // Received character that requests a dump
  localparam logic [7:0] DUMP_CMD = "a";

  // Record layout, MSB first
  typedef struct packed {
    logic [3:0]          pad;
    logic [FSM_BITS-1:0] fsm_state;
    logic [FSM_BITS-1:0] fsm_snext;
    logic [DDL_BITS-1:0] ddl_state;
    logic [CMD_BITS-1:0] cfg_cmd;
    logic                cfg_rst_n;
    logic                cfg_run;
    logic                cfg_req;
    logic                cfg_ref;
  } rec_t;

  // Dump control FSM
  typedef enum logic [1:0] {
    IDLE,
    DUMP,
    DRAIN
  } dump_state_e;

  // Hex conversion FSM
  typedef enum logic [1:0] {
    WAIT,
    DIGIT,
    EOL
  } hex_state_e;

endpackage

// File: logic/dump_ctrl.sv
module dump_ctrl (
  input  logic       clock,
  input  logic       arst_n,
  input  logic       send_ni,
  input  logic       rx_valid_i,
  input  logic [7:0] rx_data_i,
  input  logic       fifo_empty_i,
  input  logic       hex_busy_i,
  input  logic       tx_ready_i,
  output logic       dumping_o
);

  import tele_pkg::*;

  dump_state_e state_q;
  dump_state_e state_d;
  logic        send_meta;
  logic        send_sync;
  logic        send_prev;
  logic        btn_fall;
  logic        cmd_hit;

  // Button idles high, so the chain resets to one
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      send_meta <= 1'b1;
      send_sync <= 1'b1;
      send_prev <= 1'b1;
    end else begin
      send_meta <= send_ni;
      send_sync <= send_meta;
      send_prev <= send_sync;
    end
  end

  assign btn_fall = send_prev & ~send_sync;
  assign cmd_hit  = rx_valid_i && (rx_data_i == DUMP_CMD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (btn_fall || cmd_hit) begin
          state_d = DUMP;
        end
      end
      DUMP: begin
        if (fifo_empty_i) begin
          state_d = DRAIN;
        end
      end
      // Wait for the last character to leave the line
      DRAIN: begin
        if (fifo_empty_i && !hex_busy_i && tx_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign dumping_o = (state_q != IDLE);

endmodule

// File: logic/tele_capture.sv
module tele_capture #(
  parameter int DEPTH = 16
) (
  input  logic                          clock,
  input  logic                          arst_n,
  input  logic [tele_pkg::FSM_BITS-1:0] fsm_state_i,
  input  logic [tele_pkg::FSM_BITS-1:0] fsm_snext_i,
  input  logic [tele_pkg::DDL_BITS-1:0] ddl_state_i,
  input  logic [tele_pkg::CMD_BITS-1:0] cfg_cmd_i,
  input  logic                          cfg_rst_ni,
  input  logic                          cfg_run_i,
  input  logic                          cfg_req_i,
  input  logic                          cfg_ref_i,
  input  logic                          dumping_i,
  output logic                          rec_valid_o,
  input  logic                          rec_ready_i,
  output tele_pkg::rec_t                rec_data_o,
  output logic                          fifo_empty_o,
  output logic [$clog2(DEPTH):0]        level_o
);

  import tele_pkg::*;

  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int LVL_BITS = PTR_BITS + 1;

  rec_t                rec_now;
  rec_t                rec_prev;
  rec_t                mem [DEPTH];
  logic [PTR_BITS-1:0] wptr_q;
  logic [PTR_BITS-1:0] rptr_q;
  logic [LVL_BITS-1:0] level_q;
  logic                changed;
  logic                full;
  logic                push;
  logic                pop;

  always_comb begin
    rec_now           = '0;
    rec_now.fsm_state = fsm_state_i;
    rec_now.fsm_snext = fsm_snext_i;
    rec_now.ddl_state = ddl_state_i;
    rec_now.cfg_cmd   = cfg_cmd_i;
    rec_now.cfg_rst_n = cfg_rst_ni;
    rec_now.cfg_run   = cfg_run_i;
    rec_now.cfg_req   = cfg_req_i;
    rec_now.cfg_ref   = cfg_ref_i;
  end

  // Compare value tracks the inputs even while frozen
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rec_prev <= '0;
    end else begin
      rec_prev <= rec_now;
    end
  end

  assign changed = (rec_now != rec_prev);
  assign full    = (level_q == LVL_BITS'(DEPTH));
  assign push    = changed && !dumping_i && !full;
  assign pop     = rec_valid_o && rec_ready_i;

  always_ff @(posedge clock) begin
    if (push) begin
      mem[wptr_q] <= rec_now;
    end
  end

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  assign fifo_empty_o = (level_q == '0);
  assign rec_valid_o  = !fifo_empty_o;
  assign rec_data_o   = mem[rptr_q];
  assign level_o      = level_q;

endmodule

// File: logic/hex_dump.sv
module hex_dump (
  input  logic           clock,
  input  logic           arst_n,
  input  logic           dumping_i,
  input  logic           rec_valid_i,
  output logic           rec_ready_o,
  input  tele_pkg::rec_t rec_data_i,
  output logic           tx_valid_o,
  input  logic           tx_ready_i,
  output logic [7:0]     tx_data_o,
  output logic           hex_busy_o
);

  import tele_pkg::*;

  localparam int CNT_BITS = $clog2(DIGITS);

  hex_state_e          state_q;
  logic [REC_BITS-1:0] shift_q;
  logic [CNT_BITS-1:0] cnt_q;
  logic                pop;
  logic                sent;

  // Nibble to upper-case ASCII
  function automatic logic [7:0] to_ascii(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return 8'("0") + 8'(nib);
    end
    return 8'("A") + 8'(nib) - 8'd10;
  endfunction

  assign rec_ready_o = dumping_i && (state_q == WAIT);
  assign pop         = rec_valid_i && rec_ready_o;
  assign tx_valid_o  = (state_q != WAIT);
  assign sent        = tx_valid_o && tx_ready_i;
  assign hex_busy_o  = (state_q != WAIT);

  always_comb begin
    if (state_q == EOL) begin
      tx_data_o = LINE_END;
    end else begin
      tx_data_o = to_ascii(shift_q[REC_BITS-1 -: 4]);
    end
  end

  // Most significant digit goes out first
  always_ff @(posedge clock) begin
    if (pop) begin
      shift_q <= rec_data_i;
    end else if (sent && state_q == DIGIT) begin
      shift_q <= {shift_q[REC_BITS-5:0], 4'h0};
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= WAIT;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        WAIT: begin
          if (pop) begin
            state_q <= DIGIT;
            cnt_q   <= '0;
          end
        end
        DIGIT: begin
          if (sent) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_BITS'(DIGITS - 1)) begin
              state_q <= EOL;
            end
          end
        end
        EOL: begin
          if (sent) begin
            state_q <= WAIT;
          end
        end
        default: state_q <= WAIT;
      endcase
    end
  end

endmodule

// File: logic/uart_tx.sv
module uart_tx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clock,
  input  logic       arst_n,
  input  logic       tx_valid_i,
  output logic       tx_ready_o,
  input  logic [7:0] tx_data_i,
  output logic       uart_tx_o
);

  localparam int DIV_BITS = $clog2(CLKS_PER_BIT);

  logic                busy_q;
  logic [DIV_BITS-1:0] div_q;
  logic [3:0]          bit_q;
  logic [8:0]          shift_q;
  logic                line_q;
  logic                bit_end;

  assign tx_ready_o = !busy_q;
  assign bit_end    = (div_q == DIV_BITS'(CLKS_PER_BIT - 1));

  // Data bits then the stop bit, shifted out LSB first
  always_ff @(posedge clock) begin
    if (tx_valid_i && !busy_q) begin
      shift_q <= {1'b1, tx_data_i};
    end else if (busy_q && bit_end) begin
      shift_q <= {1'b1, shift_q[8:1]};
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      div_q  <= '0;
      bit_q  <= '0;
      line_q <= 1'b1;
    end else if (!busy_q) begin
      if (tx_valid_i) begin
        busy_q <= 1'b1;
        div_q  <= '0;
        bit_q  <= '0;
        // Start bit
        line_q <= 1'b0;
      end
    end else if (bit_end) begin
      div_q <= '0;
      if (bit_q == 4'd9) begin
        busy_q <= 1'b0;
      end else begin
        line_q <= shift_q[0];
        bit_q  <= bit_q + 1'b1;
      end
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  assign uart_tx_o = line_q;

endmodule

// File: logic/uart_rx.sv
module uart_rx #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic       clock,
  input  logic       arst_n,
  input  logic       uart_rx_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_data_o
);

  localparam int DIV_BITS = $clog2(CLKS_PER_BIT);

  logic                rx_meta;
  logic                rx_sync;
  logic                rx_prev;
  logic                busy_q;
  logic [DIV_BITS-1:0] div_q;
  logic [3:0]          bit_q;
  logic [7:0]          shift_q;
  logic                valid_q;

  // Line idles high
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= uart_rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clock) begin
    if (busy_q && div_q == '0 && bit_q != 4'd0 && bit_q != 4'd9) begin
      shift_q <= {rx_sync, shift_q[7:1]};
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      busy_q  <= 1'b0;
      div_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      if (!busy_q) begin
        if (rx_prev && !rx_sync) begin
          // Half a bit to land in the middle of the start bit
          busy_q <= 1'b1;
          div_q  <= DIV_BITS'(CLKS_PER_BIT / 2 - 1);
          bit_q  <= '0;
        end
      end else if (div_q != '0) begin
        div_q <= div_q - 1'b1;
      end else begin
        div_q <= DIV_BITS'(CLKS_PER_BIT - 1);
        bit_q <= bit_q + 1'b1;
        if (bit_q == 4'd0 && rx_sync) begin
          // Glitch, not a start bit
          busy_q <= 1'b0;
        end else if (bit_q == 4'd9) begin
          busy_q  <= 1'b0;
          valid_q <= rx_sync;
        end
      end
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_data_o  = shift_q;

endmodule

// File: logic/tele_uart_top.sv
module tele_uart_top #(
  parameter int DEPTH = 16,
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                          clock,
  input  logic                          arst_n,
  input  logic [tele_pkg::FSM_BITS-1:0] fsm_state_i,
  input  logic [tele_pkg::FSM_BITS-1:0] fsm_snext_i,
  input  logic [tele_pkg::DDL_BITS-1:0] ddl_state_i,
  input  logic [tele_pkg::CMD_BITS-1:0] cfg_cmd_i,
  input  logic                          cfg_rst_ni,
  input  logic                          cfg_run_i,
  input  logic                          cfg_req_i,
  input  logic                          cfg_ref_i,
  input  logic                          send_ni,
  input  logic                          uart_rx_i,
  output logic                          uart_tx_o,
  output logic [$clog2(DEPTH):0]        tele_level_o,
  output logic                          dumping_o
);

  import tele_pkg::*;

  // Record stream
  logic       rec_valid;
  logic       rec_ready;
  rec_t       rec_data;
  logic       fifo_empty;
  logic       hex_busy;

  // Character streams
  logic       tx_valid;
  logic       tx_ready;
  logic [7:0] tx_data;
  logic       rx_valid;
  logic [7:0] rx_data;

  dump_ctrl i_dump_ctrl (
    .clock        (clock),
    .arst_n       (arst_n),
    .send_ni      (send_ni),
    .rx_valid_i   (rx_valid),
    .rx_data_i    (rx_data),
    .fifo_empty_i (fifo_empty),
    .hex_busy_i   (hex_busy),
    .tx_ready_i   (tx_ready),
    .dumping_o    (dumping_o)
  );

  tele_capture #(
    .DEPTH (DEPTH)
  ) i_tele_capture (
    .clock        (clock),
    .arst_n       (arst_n),
    .fsm_state_i  (fsm_state_i),
    .fsm_snext_i  (fsm_snext_i),
    .ddl_state_i  (ddl_state_i),
    .cfg_cmd_i    (cfg_cmd_i),
    .cfg_rst_ni   (cfg_rst_ni),
    .cfg_run_i    (cfg_run_i),
    .cfg_req_i    (cfg_req_i),
    .cfg_ref_i    (cfg_ref_i),
    .dumping_i    (dumping_o),
    .rec_valid_o  (rec_valid),
    .rec_ready_i  (rec_ready),
    .rec_data_o   (rec_data),
    .fifo_empty_o (fifo_empty),
    .level_o      (tele_level_o)
  );

  hex_dump i_hex_dump (
    .clock       (clock),
    .arst_n      (arst_n),
    .dumping_i   (dumping_o),
    .rec_valid_i (rec_valid),
    .rec_ready_o (rec_ready),
    .rec_data_i  (rec_data),
    .tx_valid_o  (tx_valid),
    .tx_ready_i  (tx_ready),
    .tx_data_o   (tx_data),
    .hex_busy_o  (hex_busy)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_tx (
    .clock      (clock),
    .arst_n     (arst_n),
    .tx_valid_i (tx_valid),
    .tx_ready_o (tx_ready),
    .tx_data_i  (tx_data),
    .uart_tx_o  (uart_tx_o)
  );

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) i_uart_rx (
    .clock      (clock),
    .arst_n     (arst_n),
    .uart_rx_i  (uart_rx_i),
    .rx_valid_o (rx_valid),
    .rx_data_o  (rx_data)
  );

endmodule

// File: sim/tb_tele_uart_top.sv
module tb_tele_uart_top;

  import tele_pkg::*;

  localparam int DEPTH = 4;
  localparam int CLKS = 8;
  localparam int HOLD = 5;
  localparam int LVL_W = $clog2(DEPTH) + 1;
  localparam int START_LIMIT = 300;
  localparam int END_LIMIT = 4000;
  localparam logic [7:0] NL = 8'h0A;

  // Watched state as one vector, same field order as a record
  typedef struct packed {
    logic [FSM_BITS-1:0] fs;
    logic [FSM_BITS-1:0] fn;
    logic [DDL_BITS-1:0] ddl;
    logic [CMD_BITS-1:0] cmd;
    logic                rst_n;
    logic                run;
    logic                req;
    logic                refresh;
  } vec_t;

  logic                clock;
  logic                arst_n;
  logic [FSM_BITS-1:0] fsm_state;
  logic [FSM_BITS-1:0] fsm_snext;
  logic [DDL_BITS-1:0] ddl_state;
  logic [CMD_BITS-1:0] cfg_cmd;
  logic                cfg_rst_n;
  logic                cfg_run;
  logic                cfg_req;
  logic                cfg_ref;
  logic                send_ni;
  logic                uart_rx_i;
  logic                uart_tx_o;
  logic [LVL_W-1:0]    tele_level_o;
  logic                dumping_o;

  // Stimulus table with the expected text of each record
  vec_t        fixed_vec [6];
  string       fixed_txt [6];
  vec_t        rand_vec [3];
  string       exp_q [$];
  logic [7:0]  got_q [$];
  logic [23:0] last_rec;
  int          err_cnt;
  int          chk_cnt;
  int          test_cnt;
  int          test_fail;
  int          test_err0;
  string       test_name;

  tele_uart_top #(
    .DEPTH        (DEPTH),
    .CLKS_PER_BIT (CLKS)
  ) i_tele_uart_top (
    .clock        (clock),
    .arst_n       (arst_n),
    .fsm_state_i  (fsm_state),
    .fsm_snext_i  (fsm_snext),
    .ddl_state_i  (ddl_state),
    .cfg_cmd_i    (cfg_cmd),
    .cfg_rst_ni   (cfg_rst_n),
    .cfg_run_i    (cfg_run),
    .cfg_req_i    (cfg_req),
    .cfg_ref_i    (cfg_ref),
    .send_ni      (send_ni),
    .uart_rx_i    (uart_rx_i),
    .uart_tx_o    (uart_tx_o),
    .tele_level_o (tele_level_o),
    .dumping_o    (dumping_o)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  function automatic logic [23:0] pack_rec(vec_t v);
    return {4'h0, v.fs, v.fn, v.ddl, v.cmd, v.rst_n, v.run, v.req, v.refresh};
  endfunction

  // Six upper-case digits, most significant first
  function automatic string rec_text(logic [23:0] rec);
    string digits;
    string s;
    int    d;
    digits = "0123456789ABCDEF";
    s = "";
    for (int k = 5; k >= 0; k--) begin
      d = rec[4*k +: 4];
      s = {s, digits.substr(d, d)};
    end
    return s;
  endfunction

  task automatic check_eq(string what, logic [31:0] exp, logic [31:0] act);
    chk_cnt++;
    assert (act === exp) else begin
      $display("ERR %s: expected %0h, actual %0h", what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic note_error(string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic start_test(string name);
    test_name = name;
    test_err0 = err_cnt;
    test_cnt++;
  endtask

  task automatic finish_test();
    if (err_cnt == test_err0) begin
      $display("test %s: ok", test_name);
    end else begin
      test_fail++;
      $display("test %s: %0d errors", test_name, err_cnt - test_err0);
    end
  endtask

  task automatic drive_vec(vec_t v);
    fsm_state = v.fs;
    fsm_snext = v.fn;
    ddl_state = v.ddl;
    cfg_cmd   = v.cmd;
    cfg_rst_n = v.rst_n;
    cfg_run   = v.run;
    cfg_req   = v.req;
    cfg_ref   = v.refresh;
  endtask

  // Model of the capture rule, kept alongside the stimulus
  task automatic apply_vec(vec_t v, string text, bit frozen);
    logic [23:0] rec;
    rec = pack_rec(v);
    if (text == "") begin
      text = rec_text(rec);
    end
    @(posedge clock);
    #2;
    drive_vec(v);
    if (rec != last_rec && !frozen && exp_q.size() < DEPTH) begin
      exp_q.push_back(text);
    end
    last_rec = rec;
    repeat (HOLD - 1) @(posedge clock);
  endtask

  task automatic pulse_button();
    @(posedge clock);
    #2;
    send_ni = 1'b0;
    repeat (4) @(posedge clock);
    #2;
    send_ni = 1'b1;
  endtask

  // 8N1 frame on the receive line
  task automatic send_byte(logic [7:0] b);
    @(posedge clock);
    #2;
    uart_rx_i = 1'b0;
    repeat (CLKS) @(posedge clock);
    #2;
    for (int i = 0; i < 8; i++) begin
      uart_rx_i = b[i];
      repeat (CLKS) @(posedge clock);
      #2;
    end
    uart_rx_i = 1'b1;
    repeat (CLKS) @(posedge clock);
    #2;
  endtask

  task automatic wait_dumping(output bit seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < START_LIMIT) begin
      @(negedge clock);
      cycles++;
      seen = (dumping_o === 1'b1);
    end
    if (!seen) begin
      note_error($sformatf("%s: dump did not start within %0d cycles", test_name, START_LIMIT));
    end
  endtask

  // Called on the first negedge of a start bit, samples near mid-bit
  task automatic read_byte();
    logic [7:0] b;
    repeat (CLKS / 2) @(negedge clock);
    if (uart_tx_o !== 1'b0) begin
      note_error($sformatf("%s: start bit on uart_tx_o too short", test_name));
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS) @(negedge clock);
      b[i] = uart_tx_o;
    end
    repeat (CLKS) @(negedge clock);
    if (uart_tx_o !== 1'b1) begin
      note_error($sformatf("%s: stop bit missing on uart_tx_o", test_name));
    end
    got_q.push_back(b);
  endtask

  task automatic collect_dump();
    bit seen;
    bit done;
    int cycles;
    got_q.delete();
    wait_dumping(seen);
    if (!seen) begin
      return;
    end
    done = 1'b0;
    cycles = 0;
    while (!done && cycles < END_LIMIT) begin
      @(negedge clock);
      cycles++;
      if (uart_tx_o === 1'b0) begin
        read_byte();
      end else if (dumping_o === 1'b0) begin
        done = 1'b1;
      end
    end
    if (!done) begin
      note_error($sformatf("%s: dump did not end in time", test_name));
    end
  endtask

  task automatic check_dump(string name);
    logic [7:0] exp_b [$];
    int         lines;
    foreach (exp_q[r]) begin
      for (int c = 0; c < 6; c++) begin
        exp_b.push_back(exp_q[r][c]);
      end
      exp_b.push_back(NL);
    end
    lines = 0;
    foreach (got_q[i]) begin
      if (got_q[i] == NL) begin
        lines++;
      end
    end
    check_eq({name, " lines"}, exp_q.size(), lines);
    check_eq({name, " byte count"}, exp_b.size(), got_q.size());
    foreach (exp_b[i]) begin
      if (i < got_q.size()) begin
        check_eq($sformatf("%s byte %0d", name, i), exp_b[i], got_q[i]);
      end
    end
    check_eq({name, " dumping_o at end"}, 0, dumping_o);
    check_eq({name, " level at end"}, 0, tele_level_o);
    exp_q.delete();
  endtask

  initial begin
    logic [19:0] raw;
    logic [19:0] prev;
    bit          idle_ok;
    bit          seen;

    void'($urandom(32'hcf774f2f));
    err_cnt = 0;
    chk_cnt = 0;
    test_cnt = 0;
    test_fail = 0;
    arst_n = 1'b0;
    send_ni = 1'b1;
    uart_rx_i = 1'b1;
    drive_vec('0);
    last_rec = '0;

    // Fields: fsm_state, fsm_snext, ddl_state, cfg_cmd, rst_n run req ref
    fixed_vec[0] = {5'd1, 5'd2, 3'd0, 3'd0, 4'b1000};
    fixed_txt[0] = "008808";
    fixed_vec[1] = {5'd2, 5'd3, 3'd1, 3'd2, 4'b1100};
    fixed_txt[1] = "010CAC";
    fixed_vec[2] = {5'd31, 5'd17, 3'd7, 3'd5, 4'b1111};
    fixed_txt[2] = "0FC7DF";
    fixed_vec[3] = {5'd10, 5'd11, 3'd2, 3'd3, 4'b1010};
    fixed_txt[3] = "052D3A";
    fixed_vec[4] = {5'd20, 5'd6, 3'd5, 3'd7, 4'b0001};
    fixed_txt[4] = "0A1AF1";
    fixed_vec[5] = {5'd7, 5'd24, 3'd4, 3'd6, 4'b1001};
    fixed_txt[5] = "03E269";

    // Top bit keeps each entry nonzero
    prev = fixed_vec[2];
    for (int i = 0; i < 3; i++) begin
      raw = $urandom;
      raw = raw | 20'h80000;
      if (raw == prev) begin
        raw[0] = ~raw[0];
      end
      rand_vec[i] = raw;
      prev = raw;
    end

    repeat (2) @(posedge clock);
    #2;
    arst_n = 1'b1;

    start_test("reset");
    @(negedge clock);
    check_eq("reset uart_tx_o", 1, uart_tx_o);
    check_eq("reset dumping_o", 0, dumping_o);
    check_eq("reset tele_level_o", 0, tele_level_o);
    idle_ok = 1'b1;
    repeat (40) begin
      @(negedge clock);
      if (uart_tx_o !== 1'b1) begin
        idle_ok = 1'b0;
      end
    end
    check_eq("reset line stays idle", 1, idle_ok);
    finish_test();

    start_test("level");
    for (int i = 0; i < 3; i++) begin
      apply_vec(fixed_vec[i], fixed_txt[i], 1'b0);
    end
    @(negedge clock);
    check_eq("level after three changes", 3, tele_level_o);
    repeat (10) @(negedge clock);
    check_eq("level after hold", 3, tele_level_o);
    finish_test();

    start_test("button dump");
    fork
      pulse_button();
      collect_dump();
    join
    check_dump("button dump");
    finish_test();

    start_test("command dump");
    for (int i = 0; i < 3; i++) begin
      apply_vec(rand_vec[i], "", 1'b0);
    end
    @(negedge clock);
    check_eq("level before command", exp_q.size(), tele_level_o);
    send_byte("z");
    idle_ok = 1'b1;
    repeat (200) begin
      @(negedge clock);
      if (dumping_o !== 1'b0) begin
        idle_ok = 1'b0;
      end
    end
    check_eq("other character starts no dump", 1, idle_ok);
    fork
      send_byte("a");
      collect_dump();
    join
    check_dump("command dump");
    finish_test();

    start_test("overflow");
    for (int i = 0; i < 6; i++) begin
      apply_vec(fixed_vec[i], fixed_txt[i], 1'b0);
    end
    @(negedge clock);
    check_eq("level when full", DEPTH, tele_level_o);
    fork
      pulse_button();
      collect_dump();
    join
    check_dump("overflow dump");
    finish_test();

    start_test("freeze");
    apply_vec(fixed_vec[0], fixed_txt[0], 1'b0);
    fork
      pulse_button();
      collect_dump();
      begin
        wait_dumping(seen);
        apply_vec(fixed_vec[3], fixed_txt[3], 1'b1);
        apply_vec(fixed_vec[4], fixed_txt[4], 1'b1);
      end
    join
    check_dump("frozen dump");
    apply_vec(fixed_vec[1], fixed_txt[1], 1'b0);
    @(negedge clock);
    check_eq("level after freeze", 1, tele_level_o);
    fork
      pulse_button();
      collect_dump();
    join
    check_dump("dump after freeze");
    finish_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, test_fail, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
logic/tele_pkg.sv
logic/dump_ctrl.sv
logic/tele_capture.sv
logic/hex_dump.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/tele_uart_top.sv
sim/tb_tele_uart_top.sv

// File: Bender.yml
package:
  name: tele_uart

sources:
  - target: any(rtl, simulation)
    files:
      - logic/tele_pkg.sv
      - logic/dump_ctrl.sv
      - logic/tele_capture.sv
      - logic/hex_dump.sv
      - logic/uart_tx.sv
      - logic/uart_rx.sv
      - logic/tele_uart_top.sv
  - target: simulation
    files:
      - sim/tb_tele_uart_top.sv
